/* logic/lsq_pkg.sv */
// Store unit package
// Queue sizes, slot index and payload types for the store side of the LSQ

package lsq_pkg;

    // ========================================================================
    // Sizes
    // ========================================================================

    // Dispatch and retire width of the core
    localparam int n = 2;

    // Store queue depth
    localparam int lsq_sz = 8;

    // Memory execute lanes writing address and data
    localparam int num_fu_mem = 2;

    // Derived widths
    localparam int sq_idx_w  = $clog2(lsq_sz);
    localparam int sq_cnt_w  = $clog2(lsq_sz + 1);
    localparam int ret_cnt_w = $clog2(n + 1);
    localparam int xlen      = 32;

    // ========================================================================
    // Types
    // ========================================================================

    // Slot index into the circular queue
    typedef logic [sq_idx_w-1:0] sq_idx_t;

    // Free slot count, 0 to lsq_sz
    typedef logic [sq_cnt_w-1:0] sq_cnt_t;

    // Per cycle count, 0 to n
    typedef logic [ret_cnt_w-1:0] ret_cnt_t;

    typedef logic [xlen-1:0] addr_t;
    typedef logic [xlen-1:0] data_t;

    // One store queue slot
    typedef struct packed {
        logic  valid;       // slot allocated at dispatch
        logic  addr_valid;  // execute has written address and data
        addr_t address;
        data_t data;
    } sq_entry_t;

endpackage

/* logic/store_queue.sv */
// Store queue
// Circular buffer of store slots with dispatch allocation, execute update,
// retire from the head and full flush on mispredict

module store_queue (
    input  logic                                          clock,
    input  logic                                          rst,

    // ========================================================================
    // Dispatch
    // ========================================================================
    // Contiguous from lane 0, never above free_slots
    input  logic              [lsq_pkg::n-1:0]            dispatch_valid,
    output lsq_pkg::sq_cnt_t                              free_slots,
    output lsq_pkg::sq_idx_t  [lsq_pkg::n-1:0]            alloc_idxs,

    // ========================================================================
    // Execute
    // ========================================================================
    input  logic              [lsq_pkg::num_fu_mem-1:0]   exe_valid,
    input  lsq_pkg::sq_idx_t  [lsq_pkg::num_fu_mem-1:0]   exe_idx,
    input  lsq_pkg::addr_t    [lsq_pkg::num_fu_mem-1:0]   exe_addr,
    input  lsq_pkg::data_t    [lsq_pkg::num_fu_mem-1:0]   exe_data,

    // ========================================================================
    // Retire and flush
    // ========================================================================
    // Stores to free from the head this cycle
    input  lsq_pkg::ret_cnt_t                             free_count,
    input  logic                                          mispredict,

    // ========================================================================
    // Queue state for forwarding and retire port
    // ========================================================================
    output lsq_pkg::sq_entry_t [lsq_pkg::lsq_sz-1:0]      sq_entries,
    output lsq_pkg::sq_idx_t                              head_idx,
    output lsq_pkg::sq_entry_t [lsq_pkg::n-1:0]           head_entries
);

    // Next state of the slot array
    lsq_pkg::sq_entry_t [lsq_pkg::lsq_sz-1:0] entries_next;

    // Pointers and counter
    lsq_pkg::sq_idx_t  tail_idx;
    lsq_pkg::sq_idx_t  head_next;
    lsq_pkg::sq_idx_t  tail_next;
    lsq_pkg::sq_cnt_t  free_next;

    // Lanes dispatched this cycle, 0 to n
    lsq_pkg::ret_cnt_t num_disp;

    // ========================================================================
    // Next state
    // ========================================================================
    always_comb begin
        entries_next = sq_entries;
        num_disp     = '0;

        // Step 1
        // Free slots at the head, payload left in place
        for (int i = 0; i < lsq_pkg::n; i++) begin
            if (i < int'(free_count)) begin
                entries_next[(int'(head_idx) + i) % lsq_pkg::lsq_sz].valid      = 1'b0;
                entries_next[(int'(head_idx) + i) % lsq_pkg::lsq_sz].addr_valid = 1'b0;
            end
        end

        head_next = lsq_pkg::sq_idx_t'((int'(head_idx) + int'(free_count))
                                       % lsq_pkg::lsq_sz);

        // Step 2
        // Allocate at the tail in lane order
        for (int i = 0; i < lsq_pkg::n; i++) begin
            if (dispatch_valid[i]) begin
                entries_next[(int'(tail_idx) + int'(num_disp)) % lsq_pkg::lsq_sz].valid
                    = 1'b1;
                // Address unknown until execute writes it
                entries_next[(int'(tail_idx) + int'(num_disp)) % lsq_pkg::lsq_sz].addr_valid
                    = 1'b0;
                num_disp = num_disp + 1'b1;
            end
        end

        tail_next = lsq_pkg::sq_idx_t'((int'(tail_idx) + int'(num_disp))
                                       % lsq_pkg::lsq_sz);

        // Step 3
        // Execute writes address and data into its slot
        for (int j = 0; j < lsq_pkg::num_fu_mem; j++) begin
            if (exe_valid[j]) begin
                entries_next[exe_idx[j]].addr_valid = 1'b1;
                entries_next[exe_idx[j]].address    = exe_addr[j];
                entries_next[exe_idx[j]].data       = exe_data[j];
            end
        end

        // Retired slots come back, dispatched ones are taken
        free_next = free_slots
                  + lsq_pkg::sq_cnt_t'(free_count)
                  - lsq_pkg::sq_cnt_t'(num_disp);
    end

    // ========================================================================
    // Allocation indices and head view
    // ========================================================================
    always_comb begin
        for (int i = 0; i < lsq_pkg::n; i++) begin
            // Lane i gets tail plus i
            alloc_idxs[i] = lsq_pkg::sq_idx_t'((int'(tail_idx) + i) % lsq_pkg::lsq_sz);
        end
    end

    always_comb begin
        for (int i = 0; i < lsq_pkg::n; i++) begin
            // Oldest entries first, lane 0 is the head
            head_entries[i] = sq_entries[(int'(head_idx) + i) % lsq_pkg::lsq_sz];
        end
    end

    // ========================================================================
    // State registers
    // ========================================================================
    always_ff @(posedge clock) begin
        // Mispredict empties the whole queue
        if (rst || mispredict) begin
            sq_entries <= '0;
            head_idx   <= '0;
            tail_idx   <= '0;
            free_slots <= lsq_pkg::sq_cnt_t'(lsq_pkg::lsq_sz);
        end else begin
            sq_entries <= entries_next;
            head_idx   <= head_next;
            tail_idx   <= tail_next;
            free_slots <= free_next;
        end
    end

endmodule

/* logic/store_forward.sv */
// Store to load forwarding search
// Finds the youngest older store matching a load address, result registered

module store_forward (
    input  logic                                     clock,
    input  logic                                     rst,

    // ========================================================================
    // Load request
    // ========================================================================
    input  logic                                     load_valid,
    input  lsq_pkg::addr_t                           load_addr,
    // Tail seen when the load was dispatched
    input  lsq_pkg::sq_idx_t                         load_sq_tail,

    // ========================================================================
    // Queue state
    // ========================================================================
    input  lsq_pkg::sq_entry_t [lsq_pkg::lsq_sz-1:0] sq_entries,
    input  lsq_pkg::sq_idx_t                         head_idx,

    // ========================================================================
    // Result
    // ========================================================================
    output logic                                     fwd_done,
    output logic                                     fwd_hit,
    output logic                                     fwd_unknown,
    output lsq_pkg::data_t                           fwd_data
);

    // Slots from head up to the tail snapshot
    lsq_pkg::sq_idx_t   older_cnt;

    // Slot under test in the walk
    lsq_pkg::sq_entry_t cand;

    // Search result before the register
    logic               hit;
    logic               unknown;
    lsq_pkg::data_t     hit_data;

    // ========================================================================
    // Search
    // ========================================================================
    always_comb begin
        // Wrapping distance, head equal to tail means no older store
        older_cnt = lsq_pkg::sq_idx_t'((int'(load_sq_tail) - int'(head_idx)
                                        + lsq_pkg::lsq_sz) % lsq_pkg::lsq_sz);

        cand     = '0;
        hit      = 1'b0;
        unknown  = 1'b0;
        hit_data = '0;

        // Oldest to youngest, so the last match wins
        for (int k = 0; k < lsq_pkg::lsq_sz; k++) begin
            cand = sq_entries[(int'(head_idx) + k) % lsq_pkg::lsq_sz];
            if (k < int'(older_cnt) && cand.valid) begin
                if (!cand.addr_valid) begin
                    // Younger store could still alias
                    unknown = 1'b1;
                    hit     = 1'b0;
                end else if (cand.address == load_addr) begin
                    hit      = 1'b1;
                    unknown  = 1'b0;
                    hit_data = cand.data;
                end
            end
        end
    end

    // ========================================================================
    // Result registers
    // ========================================================================
    always_ff @(posedge clock) begin
        if (rst) begin
            fwd_done    <= 1'b0;
            fwd_hit     <= 1'b0;
            fwd_unknown <= 1'b0;
        end else begin
            // One cycle pulse per load strobe
            fwd_done    <= load_valid;
            fwd_hit     <= load_valid && hit;
            fwd_unknown <= load_valid && unknown;
        end
    end

    // Zero data unless a hit is reported
    always_ff @(posedge clock) begin
        fwd_data <= (load_valid && hit) ? hit_data : '0;
    end

endmodule

/* logic/store_retire_port.sv */
// Store retire write port
// Registers the retired head entries as memory write strobes in age order

module store_retire_port (
    input  logic                                clock,
    input  logic                                rst,

    // ========================================================================
    // From the store queue head
    // ========================================================================
    // Lane 0 is the oldest store
    input  lsq_pkg::sq_entry_t [lsq_pkg::n-1:0] head_entries,
    // Stores retiring this cycle
    input  lsq_pkg::ret_cnt_t                   free_count,

    // ========================================================================
    // Memory write port, always accepts
    // ========================================================================
    output logic               [lsq_pkg::n-1:0] mem_wr_valid,
    output lsq_pkg::addr_t     [lsq_pkg::n-1:0] mem_wr_addr,
    output lsq_pkg::data_t     [lsq_pkg::n-1:0] mem_wr_data
);

    // ========================================================================
    // Write strobes
    // ========================================================================
    always_ff @(posedge clock) begin
        if (rst) begin
            mem_wr_valid <= '0;
        end else begin
            // Lanes below free_count fire, rest drop low
            for (int i = 0; i < lsq_pkg::n; i++) begin
                mem_wr_valid[i] <= (i < int'(free_count));
            end
        end
    end

    // ========================================================================
    // Write payload
    // ========================================================================
    always_ff @(posedge clock) begin
        for (int i = 0; i < lsq_pkg::n; i++) begin
            // Captured every cycle, qualified by mem_wr_valid
            mem_wr_addr[i] <= head_entries[i].address;
            mem_wr_data[i] <= head_entries[i].data;
        end
    end

endmodule

/* logic/store_unit_top.sv */
// Store unit top level
// Store queue with forwarding search and retire write port

module store_unit_top (
    input  logic                                          clock,
    input  logic                                          rst,

    // ========================================================================
    // Dispatch
    // ========================================================================
    input  logic              [lsq_pkg::n-1:0]            dispatch_valid,
    output lsq_pkg::sq_cnt_t                              free_slots,
    output lsq_pkg::sq_idx_t  [lsq_pkg::n-1:0]            alloc_idxs,

    // ========================================================================
    // Execute
    // ========================================================================
    input  logic              [lsq_pkg::num_fu_mem-1:0]   exe_valid,
    input  lsq_pkg::sq_idx_t  [lsq_pkg::num_fu_mem-1:0]   exe_idx,
    input  lsq_pkg::addr_t    [lsq_pkg::num_fu_mem-1:0]   exe_addr,
    input  lsq_pkg::data_t    [lsq_pkg::num_fu_mem-1:0]   exe_data,

    // ========================================================================
    // Retire and flush
    // ========================================================================
    input  lsq_pkg::ret_cnt_t                             free_count,
    input  logic                                          mispredict,

    // ========================================================================
    // Load forwarding
    // ========================================================================
    input  logic                                          load_valid,
    input  lsq_pkg::addr_t                                load_addr,
    input  lsq_pkg::sq_idx_t                              load_sq_tail,
    output logic                                          fwd_done,
    output logic                                          fwd_hit,
    output logic                                          fwd_unknown,
    output lsq_pkg::data_t                                fwd_data,

    // ========================================================================
    // Memory write port
    // ========================================================================
    output logic              [lsq_pkg::n-1:0]            mem_wr_valid,
    output lsq_pkg::addr_t    [lsq_pkg::n-1:0]            mem_wr_addr,
    output lsq_pkg::data_t    [lsq_pkg::n-1:0]            mem_wr_data
);

    // Queue state shared by the search and the write port
    lsq_pkg::sq_entry_t [lsq_pkg::lsq_sz-1:0] sq_entries;
    lsq_pkg::sq_idx_t                         head_idx;
    lsq_pkg::sq_entry_t [lsq_pkg::n-1:0]      head_entries;

    store_queue u_store_queue (
        .clock          (clock),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .free_slots     (free_slots),
        .alloc_idxs     (alloc_idxs),
        .exe_valid      (exe_valid),
        .exe_idx        (exe_idx),
        .exe_addr       (exe_addr),
        .exe_data       (exe_data),
        .free_count     (free_count),
        .mispredict     (mispredict),
        .sq_entries     (sq_entries),
        .head_idx       (head_idx),
        .head_entries   (head_entries)
    );

    // Sees queue state before the edge of the load strobe
    store_forward u_store_forward (
        .clock        (clock),
        .rst          (rst),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_sq_tail (load_sq_tail),
        .sq_entries   (sq_entries),
        .head_idx     (head_idx),
        .fwd_done     (fwd_done),
        .fwd_hit      (fwd_hit),
        .fwd_unknown  (fwd_unknown),
        .fwd_data     (fwd_data)
    );

    // Not flushed, retired stores are already committed
    store_retire_port u_store_retire_port (
        .clock        (clock),
        .rst          (rst),
        .head_entries (head_entries),
        .free_count   (free_count),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data)
    );

endmodule

/* sim/tb_store_unit.sv */
// Store unit testbench
// Per cycle stimulus table checked against a reference store queue model

module tb_store_unit;

    localparam int drive_dly  = 2;
    localparam int wait_limit = 8;

    // Forwarding outcome of a row
    localparam logic [1:0] kind_none = 2'd0;
    localparam logic [1:0] kind_miss = 2'd1;
    localparam logic [1:0] kind_hit  = 2'd2;
    localparam logic [1:0] kind_unk  = 2'd3;

    // Address shared by stores meant to hit, and one that no store uses
    localparam lsq_pkg::addr_t shared_addr = 32'h0000_4000;
    localparam lsq_pkg::addr_t miss_addr   = 32'h0000_8000;

    typedef struct packed {
        logic [1:0]                                 disp;
        logic [lsq_pkg::num_fu_mem-1:0]             e_valid;
        lsq_pkg::sq_idx_t [lsq_pkg::num_fu_mem-1:0] e_idx;
        lsq_pkg::addr_t [lsq_pkg::num_fu_mem-1:0]   e_addr;
        lsq_pkg::data_t [lsq_pkg::num_fu_mem-1:0]   e_data;
        lsq_pkg::ret_cnt_t                          fc;
        logic                                       ld_v;
        lsq_pkg::addr_t                             ld_addr;
        lsq_pkg::sq_idx_t                           ld_tail;
        logic                                       misp;
        logic [1:0]                                 kind;
    } row_t;

    logic                                       clock;
    logic                                       rst;
    logic [lsq_pkg::n-1:0]                      dispatch_valid;
    lsq_pkg::sq_cnt_t                           free_slots;
    lsq_pkg::sq_idx_t [lsq_pkg::n-1:0]          alloc_idxs;
    logic [lsq_pkg::num_fu_mem-1:0]             exe_valid;
    lsq_pkg::sq_idx_t [lsq_pkg::num_fu_mem-1:0] exe_idx;
    lsq_pkg::addr_t [lsq_pkg::num_fu_mem-1:0]   exe_addr;
    lsq_pkg::data_t [lsq_pkg::num_fu_mem-1:0]   exe_data;
    lsq_pkg::ret_cnt_t                          free_count;
    logic                                       mispredict;
    logic                                       load_valid;
    lsq_pkg::addr_t                             load_addr;
    lsq_pkg::sq_idx_t                           load_sq_tail;
    logic                                       fwd_done;
    logic                                       fwd_hit;
    logic                                       fwd_unknown;
    lsq_pkg::data_t                             fwd_data;
    logic [lsq_pkg::n-1:0]                      mem_wr_valid;
    lsq_pkg::addr_t [lsq_pkg::n-1:0]            mem_wr_addr;
    lsq_pkg::data_t [lsq_pkg::n-1:0]            mem_wr_data;

    row_t        rows [$];
    logic [31:0] rng_state;

    // Reference queue state
    logic           m_valid [lsq_pkg::lsq_sz];
    logic           m_av    [lsq_pkg::lsq_sz];
    lsq_pkg::addr_t m_addr  [lsq_pkg::lsq_sz];
    lsq_pkg::data_t m_data  [lsq_pkg::lsq_sz];
    int             m_head;
    int             m_tail;
    int             m_free;

    store_unit_top u_dut (.*);

    always #10 clock = ~clock;

    // ========================================================================
    // Failure reporting and compare tasks
    // ========================================================================
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want)
            stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, want));
    endtask

    task automatic check_count(input string name, input lsq_pkg::sq_cnt_t got,
                               input lsq_pkg::sq_cnt_t want);
        if (got !== want)
            stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, want));
    endtask

    task automatic check_idx(input string name, input lsq_pkg::sq_idx_t got,
                             input lsq_pkg::sq_idx_t want);
        if (got !== want)
            stop_on_error($sformatf("[FAIL] %s got %h expected %h", name, got, want));
    endtask

    task automatic check_write(input int lane, input lsq_pkg::addr_t got_addr,
                               input lsq_pkg::data_t got_data, input lsq_pkg::addr_t want_addr,
                               input lsq_pkg::data_t want_data);
        if (got_addr !== want_addr)
            stop_on_error($sformatf("[FAIL] mem_wr_addr[%0d] got %h expected %h",
                                    lane, got_addr, want_addr));
        if (got_data !== want_data)
            stop_on_error($sformatf("[FAIL] mem_wr_data[%0d] got %h expected %h",
                                    lane, got_data, want_data));
    endtask

    task automatic check_fwd(input logic got_hit, input logic got_unk,
                             input lsq_pkg::data_t got_data, input logic want_hit,
                             input logic want_unk, input lsq_pkg::data_t want_data);
        check_flag("fwd_hit", got_hit, want_hit);
        check_flag("fwd_unknown", got_unk, want_unk);
        if (got_data !== want_data)
            stop_on_error($sformatf("[FAIL] fwd_data got %h expected %h", got_data, want_data));
    endtask

    // ========================================================================
    // Stimulus table
    // ========================================================================
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Slot -1 means no execute on that lane, ld is 0 none, 1 shared, 2 miss
    task automatic add_row(input int disp, input int e0, input bit e0_sh, input int e1,
                           input bit e1_sh, input int fc, input int ld, input int ld_tail,
                           input bit misp, input logic [1:0] kind);
        row_t r;
        int   slot [2];
        bit   sh   [2];
        logic [31:0] rnd;
        r = '0;
        slot[0] = e0;
        slot[1] = e1;
        sh[0]   = e0_sh;
        sh[1]   = e1_sh;
        for (int j = 0; j < lsq_pkg::num_fu_mem; j++) begin
            if (slot[j] >= 0) begin
                rnd          = next_rand();
                r.e_valid[j] = 1'b1;
                r.e_idx[j]   = lsq_pkg::sq_idx_t'(slot[j]);
                // Top nibble 1 keeps random addresses off the fixed ones
                r.e_addr[j]  = sh[j] ? shared_addr : {4'h1, rnd[27:2], 2'b00};
                r.e_data[j]  = next_rand();
            end
        end
        r.disp    = 2'(disp);
        r.fc      = lsq_pkg::ret_cnt_t'(fc);
        r.ld_v    = (ld != 0);
        r.ld_addr = (ld == 1) ? shared_addr : miss_addr;
        r.ld_tail = lsq_pkg::sq_idx_t'(ld_tail);
        r.misp    = misp;
        r.kind    = kind;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Fill, execute out of order, search older stores
        add_row(2, -1, 0, -1, 0, 0, 0, 0, 0, kind_none);
        add_row(1,  1, 0,  0, 0, 0, 0, 0, 0, kind_none);
        add_row(2,  2, 1, -1, 0, 0, 0, 0, 0, kind_none);
        add_row(0,  4, 1,  3, 0, 0, 0, 0, 0, kind_none);
        add_row(1, -1, 0, -1, 0, 0, 1, 5, 0, kind_hit);
        // Tail snapshot 4 hides the younger match in slot 4
        add_row(0, -1, 0, -1, 0, 1, 1, 4, 0, kind_hit);
        add_row(2, -1, 0, -1, 0, 2, 1, 6, 0, kind_unk);
        add_row(0,  5, 0,  6, 0, 1, 0, 0, 0, kind_none);
        add_row(2,  7, 1, -1, 0, 0, 1, 0, 0, kind_unk);
        add_row(0,  0, 0,  1, 1, 2, 2, 0, 0, kind_miss);
        // Head wraps, match found past slot 7
        add_row(1, -1, 0, -1, 0, 2, 1, 2, 0, kind_hit);
        add_row(0,  2, 1, -1, 0, 0, 1, 1, 0, kind_miss);
        // Flush with a retire in the same cycle
        add_row(1, -1, 0, -1, 0, 1, 0, 0, 1, kind_none);
        add_row(2, -1, 0, -1, 0, 0, 1, 0, 0, kind_miss);
        add_row(0,  0, 1,  1, 1, 0, 0, 0, 0, kind_none);
        add_row(0, -1, 0, -1, 0, 2, 1, 2, 0, kind_hit);
        add_row(0, -1, 0, -1, 0, 0, 0, 0, 0, kind_none);
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================
    task automatic clear_model();
        for (int s = 0; s < lsq_pkg::lsq_sz; s++) begin
            m_valid[s] = 1'b0;
            m_av[s]    = 1'b0;
            m_addr[s]  = '0;
            m_data[s]  = '0;
        end
        m_head = 0;
        m_tail = 0;
        m_free = lsq_pkg::lsq_sz;
    endtask

    // Youngest older store decides, unknown address blocks any older match
    task automatic predict_forward(input lsq_pkg::addr_t a, input lsq_pkg::sq_idx_t snap,
                                   output logic [1:0] kind, output lsq_pkg::data_t d);
        int older;
        int slot;
        bit settled;
        older   = (int'(snap) - m_head + lsq_pkg::lsq_sz) % lsq_pkg::lsq_sz;
        kind    = kind_miss;
        d       = '0;
        settled = 1'b0;
        for (int k = older - 1; k >= 0; k--) begin
            slot = (m_head + k) % lsq_pkg::lsq_sz;
            if (!settled && m_valid[slot]) begin
                if (!m_av[slot]) begin
                    kind    = kind_unk;
                    settled = 1'b1;
                end else if (m_addr[slot] == a) begin
                    kind    = kind_hit;
                    d       = m_data[slot];
                    settled = 1'b1;
                end
            end
        end
    endtask

    task automatic advance_model(input row_t r);
        int slot;
        if (r.misp) begin
            clear_model();
        end else begin
            for (int i = 0; i < int'(r.fc); i++) begin
                slot          = (m_head + i) % lsq_pkg::lsq_sz;
                m_valid[slot] = 1'b0;
                m_av[slot]    = 1'b0;
            end
            m_head = (m_head + int'(r.fc)) % lsq_pkg::lsq_sz;
            for (int i = 0; i < int'(r.disp); i++) begin
                slot          = (m_tail + i) % lsq_pkg::lsq_sz;
                m_valid[slot] = 1'b1;
                m_av[slot]    = 1'b0;
            end
            m_tail = (m_tail + int'(r.disp)) % lsq_pkg::lsq_sz;
            for (int j = 0; j < lsq_pkg::num_fu_mem; j++) begin
                if (r.e_valid[j]) begin
                    m_av[r.e_idx[j]]   = 1'b1;
                    m_addr[r.e_idx[j]] = r.e_addr[j];
                    m_data[r.e_idx[j]] = r.e_data[j];
                end
            end
            m_free = m_free + int'(r.fc) - int'(r.disp);
        end
    endtask

    // ========================================================================
    // Drive and wait
    // ========================================================================
    task automatic drive_idle();
        dispatch_valid = '0;
        exe_valid      = '0;
        exe_idx        = '0;
        exe_addr       = '0;
        exe_data       = '0;
        free_count     = '0;
        mispredict     = 1'b0;
        load_valid     = 1'b0;
        load_addr      = '0;
        load_sq_tail   = '0;
    endtask

    task automatic drive_row(input row_t r);
        for (int i = 0; i < lsq_pkg::n; i++)
            dispatch_valid[i] = (i < int'(r.disp));
        exe_valid    = r.e_valid;
        exe_idx      = r.e_idx;
        exe_addr     = r.e_addr;
        exe_data     = r.e_data;
        free_count   = r.fc;
        mispredict   = r.misp;
        load_valid   = r.ld_v;
        load_addr    = r.ld_addr;
        load_sq_tail = r.ld_tail;
    endtask

    task automatic wait_fwd_done();
        int cycles;
        cycles = 0;
        while (fwd_done !== 1'b1 && cycles < wait_limit) begin
            @(posedge clock);
            #drive_dly;
            cycles++;
        end
        if (fwd_done !== 1'b1)
            stop_on_error("timed out waiting for fwd_done after a load");
        else if (cycles != 0)
            stop_on_error("fwd_done came later than one cycle after the load");
    endtask

    task automatic wait_mem_write();
        int cycles;
        cycles = 0;
        while (mem_wr_valid[0] !== 1'b1 && cycles < wait_limit) begin
            @(posedge clock);
            #drive_dly;
            cycles++;
        end
        if (mem_wr_valid[0] !== 1'b1)
            stop_on_error("timed out waiting for mem_wr_valid after a retire");
        else if (cycles != 0)
            stop_on_error("mem_wr_valid came later than one cycle after the retire");
    endtask

    // One table row, expected values taken before the model steps
    task automatic run_row(input row_t r);
        logic [1:0]     kind;
        lsq_pkg::data_t want_fwd;
        lsq_pkg::addr_t want_addr [lsq_pkg::n];
        lsq_pkg::data_t want_data [lsq_pkg::n];
        int             slot;
        drive_row(r);
        kind     = kind_none;
        want_fwd = '0;
        if (r.ld_v)
            predict_forward(r.ld_addr, r.ld_tail, kind, want_fwd);
        if (kind != r.kind)
            stop_on_error("reference model forwarding outcome differs from the stimulus table");
        for (int i = 0; i < lsq_pkg::n; i++) begin
            slot         = (m_head + i) % lsq_pkg::lsq_sz;
            want_addr[i] = m_addr[slot];
            want_data[i] = m_data[slot];
        end
        advance_model(r);
        @(posedge clock);
        #drive_dly;
        drive_idle();
        check_count("free_slots", free_slots, lsq_pkg::sq_cnt_t'(m_free));
        for (int i = 0; i < lsq_pkg::n; i++)
            check_idx($sformatf("alloc_idxs[%0d]", i), alloc_idxs[i],
                      lsq_pkg::sq_idx_t'((m_tail + i) % lsq_pkg::lsq_sz));
        if (r.ld_v) begin
            wait_fwd_done();
            check_fwd(fwd_hit, fwd_unknown, fwd_data, kind == kind_hit, kind == kind_unk,
                      want_fwd);
        end else begin
            check_flag("fwd_done", fwd_done, 1'b0);
        end
        if (r.fc != 0)
            wait_mem_write();
        for (int i = 0; i < lsq_pkg::n; i++) begin
            check_flag($sformatf("mem_wr_valid[%0d]", i), mem_wr_valid[i], i < int'(r.fc));
            if (i < int'(r.fc))
                check_write(i, mem_wr_addr[i], mem_wr_data[i], want_addr[i], want_data[i]);
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        rng_state = 32'h4523_c974;
        clock     = 1'b0;
        rst       = 1'b1;
        drive_idle();
        clear_model();
        build_table();
        repeat (10) @(posedge clock);
        #drive_dly;
        rst = 1'b0;
        // Queue empty, pointers at slot 0, no strobes
        check_count("free_slots", free_slots, lsq_pkg::sq_cnt_t'(lsq_pkg::lsq_sz));
        check_idx("alloc_idxs[0]", alloc_idxs[0], lsq_pkg::sq_idx_t'(0));
        check_idx("alloc_idxs[1]", alloc_idxs[1], lsq_pkg::sq_idx_t'(1));
        check_flag("fwd_done", fwd_done, 1'b0);
        check_flag("fwd_hit", fwd_hit, 1'b0);
        check_flag("fwd_unknown", fwd_unknown, 1'b0);
        check_flag("mem_wr_valid[0]", mem_wr_valid[0], 1'b0);
        check_flag("mem_wr_valid[1]", mem_wr_valid[1], 1'b0);
        foreach (rows[i])
            run_row(rows[i]);
        $display("TEST OK");
        $finish;
    end

endmodule

/* build.f */
logic/lsq_pkg.sv
logic/store_queue.sv
logic/store_forward.sv
logic/store_retire_port.sv
logic/store_unit_top.sv
sim/tb_store_unit.sv

/* Bender.yml */
package:
  name: store_unit

sources:
  # RTL, package first
  - target: rtl
    files:
      - logic/lsq_pkg.sv
      - logic/store_queue.sv
      - logic/store_forward.sv
      - logic/store_retire_port.sv
      - logic/store_unit_top.sv

  # Testbench
  - target: simulation
    files:
      - sim/tb_store_unit.sv
